// File: logic/rename_pkg.sv
/*
 * Shared widths, instruction records and reset constants for the rename stage.
 * Modules refer to these by scoped name.
 */
`default_nettype none

package rename_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register file sizes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 64;

  // Registers above the identity mapping start out free.
  localparam int num_free_regs = num_phys_regs - num_arch_regs;

  // Fewer free registers than this cannot cover a full pair.
  localparam int stall_level = 2;

  typedef logic [4:0] arch_reg_t;
  typedef logic [5:0] phys_reg_t;
  typedef logic [6:0] free_count_t;
  typedef logic [4:0] free_ptr_t;
  typedef logic [1:0] pair_count_t;

  // First register handed out after reset.
  localparam phys_reg_t first_free_preg = phys_reg_t'(num_arch_regs);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction records.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Decoded instruction from the decoder.
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] immediate;
    arch_reg_t   rs_1;
    arch_reg_t   rs_2;
    arch_reg_t   rd;
    logic        writes;
    logic        jumps;
  } instr_in_t;

  // Renamed instruction toward issue.
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] immediate;
    phys_reg_t   prs_1;
    phys_reg_t   prs_2;
    arch_reg_t   rd;
    phys_reg_t   prd;      // zero when not renamed
    phys_reg_t   prd_old;  // zero when not renamed
    logic        jumps;
    logic        tag;
  } instr_out_t;

  // One register handed back by retirement.
  typedef struct packed {
    logic      valid;
    phys_reg_t preg;
  } release_t;

endpackage

`default_nettype wire

// File: logic/free_list.sv
/*
 * Circular queue of free physical registers. The two oldest entries and the
 * count are visible combinationally; pops and pushes land at the clock edge.
 */
`default_nettype none

module free_list (
  input  logic                            gsi,
  input  logic                            reset,
  input  rename_pkg::pair_count_t         alloc_count,
  input  rename_pkg::release_t      [1:0] release_in,
  output rename_pkg::phys_reg_t     [1:0] free_head,
  output rename_pkg::free_count_t         free_count
);

  rename_pkg::phys_reg_t queue [rename_pkg::num_free_regs];

  rename_pkg::free_ptr_t   rd_ptr;
  rename_pkg::free_ptr_t   wr_ptr;
  rename_pkg::free_ptr_t   rd_next;
  rename_pkg::free_ptr_t   wr_next;
  rename_pkg::pair_count_t push_count;

  // Pointers wrap at 32 on their own.
  assign rd_next = rd_ptr + rename_pkg::free_ptr_t'(1);
  assign wr_next = wr_ptr + rename_pkg::free_ptr_t'(1);

  assign push_count = {1'b0, release_in[0].valid} + {1'b0, release_in[1].valid};

  assign free_head[0] = queue[rd_ptr];
  assign free_head[1] = queue[rd_next];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge gsi) begin
    if (reset) begin
      // Registers 32 to 63 in ascending order.
      for (int i = 0; i < rename_pkg::num_free_regs; i++) begin
        queue[i] <= rename_pkg::first_free_preg + rename_pkg::phys_reg_t'(i);
      end
    end else begin
      if (release_in[0].valid) begin
        queue[wr_ptr] <= release_in[0].preg;
      end
      // Element 1 goes behind element 0 when both return.
      if (release_in[1].valid) begin
        queue[release_in[0].valid ? wr_next : wr_ptr] <= release_in[1].preg;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and count.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge gsi) begin
    if (reset) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      free_count <= rename_pkg::free_count_t'(rename_pkg::num_free_regs);
    end else begin
      rd_ptr     <= rd_ptr + rename_pkg::free_ptr_t'(alloc_count);
      wr_ptr     <= wr_ptr + rename_pkg::free_ptr_t'(push_count);
      free_count <= free_count
                    + rename_pkg::free_count_t'(push_count)
                    - rename_pkg::free_count_t'(alloc_count);
    end
  end

  // Retirement never hands back more than the queue can hold.
  a_no_push_full: assert property (
    @(posedge gsi) disable iff (reset)
    push_count != 2'd0 |->
      free_count + push_count <= rename_pkg::num_free_regs + alloc_count
  );

endmodule

`default_nettype wire

// File: logic/rename_table.sv
/*
 * Architectural to physical register map. Four source lookups and two
 * displaced-register lookups are combinational; two writes land at the edge.
 */
`default_nettype none

module rename_table (
  input  logic                        gsi,
  input  logic                        reset,
  input  rename_pkg::arch_reg_t [3:0] rd_addr,
  output rename_pkg::phys_reg_t [3:0] rd_data,
  input  rename_pkg::arch_reg_t [1:0] old_addr,
  output rename_pkg::phys_reg_t [1:0] old_data,
  input  logic                  [1:0] wr_en,
  input  rename_pkg::arch_reg_t [1:0] wr_addr,
  input  rename_pkg::phys_reg_t [1:0] wr_data
);

  rename_pkg::phys_reg_t map [rename_pkg::num_arch_regs];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lookups.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rd_data[i] = map[rd_addr[i]];
    end
    for (int i = 0; i < 2; i++) begin
      old_data[i] = map[old_addr[i]];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Updates.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge gsi) begin
    if (reset) begin
      // Identity mapping.
      for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
        map[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else begin
      // Port 1 is written last, so it wins on the same register.
      for (int p = 0; p < 2; p++) begin
        if (wr_en[p] && wr_addr[p] != '0) begin
          map[wr_addr[p]] <= wr_data[p];
        end
      end
    end
  end

  // x0 is never renamed by the resolver.
  a_no_write_x0: assert property (
    @(posedge gsi) disable iff (reset)
    !(wr_en[0] && wr_addr[0] == '0) && !(wr_en[1] && wr_addr[1] == '0)
  );

endmodule

`default_nettype wire

// File: logic/resolver.sv
/*
 * Renames a decoded pair in one cycle: table lookups, in-pair forwarding,
 * free-list allocation, speculation tags and the stall toward the decoder.
 */
`default_nettype none

module resolver (
  input  logic                              gsi,
  input  logic                              reset,
  input  logic                              in_valid,
  input  rename_pkg::instr_in_t       [1:0] in_instr,
  input  logic                              resolve,
  output logic                              stall,
  output logic                              out_valid,
  output rename_pkg::instr_out_t      [1:0] out_instr,
  output rename_pkg::arch_reg_t       [3:0] rd_addr,
  input  rename_pkg::phys_reg_t       [3:0] rd_data,
  output rename_pkg::arch_reg_t       [1:0] old_addr,
  input  rename_pkg::phys_reg_t       [1:0] old_data,
  output logic                        [1:0] wr_en,
  output rename_pkg::arch_reg_t       [1:0] wr_addr,
  output rename_pkg::phys_reg_t       [1:0] wr_data,
  input  rename_pkg::phys_reg_t       [1:0] free_head,
  input  rename_pkg::free_count_t           free_count,
  output rename_pkg::pair_count_t           alloc_count
);

  logic                              accept;
  logic                        [1:0] renames;
  logic                              tag_active;
  rename_pkg::phys_reg_t       [1:0] new_preg;
  rename_pkg::instr_out_t      [1:0] renamed;

  // Source depends on a renaming older instruction.
  function automatic logic depends(input logic writer_renames,
                                   input rename_pkg::arch_reg_t rd,
                                   input rename_pkg::arch_reg_t rs);
    return writer_renames && rd == rs;
  endfunction

  assign stall  = free_count < rename_pkg::free_count_t'(rename_pkg::stall_level);
  assign accept = in_valid && !stall;

  assign renames[0] = in_instr[0].writes && in_instr[0].rd != '0;
  assign renames[1] = in_instr[1].writes && in_instr[1].rd != '0;

  // First renaming instruction takes head 0.
  assign new_preg[0] = renames[0] ? free_head[0] : '0;
  assign new_preg[1] = !renames[1] ? '0 : (renames[0] ? free_head[1] : free_head[0]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table and free-list requests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_addr  = {in_instr[1].rs_2, in_instr[1].rs_1, in_instr[0].rs_2, in_instr[0].rs_1};
  assign old_addr = {in_instr[1].rd, in_instr[0].rd};

  assign wr_en   = accept ? renames : 2'b00;
  assign wr_addr = {in_instr[1].rd, in_instr[0].rd};
  assign wr_data = new_preg;

  assign alloc_count = accept ? {1'b0, renames[0]} + {1'b0, renames[1]} : 2'd0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Renamed pair.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    renamed[0].address   = in_instr[0].address;
    renamed[0].immediate = in_instr[0].immediate;
    renamed[0].prs_1     = rd_data[0];
    renamed[0].prs_2     = rd_data[1];
    renamed[0].rd        = in_instr[0].rd;
    renamed[0].prd       = new_preg[0];
    renamed[0].prd_old   = renames[0] ? old_data[0] : '0;
    renamed[0].jumps     = in_instr[0].jumps;
    renamed[0].tag       = in_instr[0].jumps ? 1'b0 : tag_active;

    renamed[1].address   = in_instr[1].address;
    renamed[1].immediate = in_instr[1].immediate;
    renamed[1].prs_1     = depends(renames[0], in_instr[0].rd, in_instr[1].rs_1) ?
                           new_preg[0] : rd_data[2];
    renamed[1].prs_2     = depends(renames[0], in_instr[0].rd, in_instr[1].rs_2) ?
                           new_preg[0] : rd_data[3];
    renamed[1].rd        = in_instr[1].rd;
    renamed[1].prd       = new_preg[1];
    // Same destination displaces the older one's fresh register.
    if (!renames[1]) begin
      renamed[1].prd_old = '0;
    end else if (depends(renames[0], in_instr[0].rd, in_instr[1].rd)) begin
      renamed[1].prd_old = new_preg[0];
    end else begin
      renamed[1].prd_old = old_data[1];
    end
    renamed[1].jumps     = in_instr[1].jumps;
    if (in_instr[1].jumps) begin
      renamed[1].tag = 1'b0;
    end else if (in_instr[0].jumps) begin
      renamed[1].tag = 1'b1;
    end else begin
      renamed[1].tag = tag_active;
    end
  end

  always_ff @(posedge gsi) begin
    if (reset) begin
      out_valid  <= 1'b0;
      tag_active <= 1'b0;
    end else begin
      out_valid <= accept;
      // A new jump outranks a resolve of an older one.
      if (accept && (in_instr[0].jumps || in_instr[1].jumps)) begin
        tag_active <= 1'b1;
      end else if (resolve) begin
        tag_active <= 1'b0;
      end
    end
  end

  always_ff @(posedge gsi) begin
    if (accept) begin
      out_instr <= renamed;
    end
  end

  // Decoder holds off while stalled.
  a_no_valid_in_stall: assert property (
    @(posedge gsi) disable iff (reset) in_valid |-> !stall
  );

  a_alloc_covered: assert property (
    @(posedge gsi) disable iff (reset) alloc_count <= free_count
  );

endmodule

`default_nettype wire

// File: logic/rename_stage.sv
/*
 * Register-rename stage for a two-wide core. Takes a decoded pair each cycle
 * and returns it renamed one cycle later; retirement frees registers here.
 */
`default_nettype none

module rename_stage (
  input  logic                         gsi,
  input  logic                         reset,
  input  logic                         in_valid,
  input  rename_pkg::instr_in_t  [1:0] in_instr,
  input  rename_pkg::release_t   [1:0] release_in,
  input  logic                         resolve,
  output logic                         stall,
  output logic                         out_valid,
  output rename_pkg::instr_out_t [1:0] out_instr
);

  rename_pkg::arch_reg_t   [3:0] rd_addr;
  rename_pkg::phys_reg_t   [3:0] rd_data;
  rename_pkg::arch_reg_t   [1:0] old_addr;
  rename_pkg::phys_reg_t   [1:0] old_data;
  logic                    [1:0] wr_en;
  rename_pkg::arch_reg_t   [1:0] wr_addr;
  rename_pkg::phys_reg_t   [1:0] wr_data;
  rename_pkg::phys_reg_t   [1:0] free_head;
  rename_pkg::free_count_t       free_count;
  rename_pkg::pair_count_t       alloc_count;

  resolver u_resolver (
    .gsi, .reset, .in_valid, .in_instr, .resolve,
    .stall, .out_valid, .out_instr,
    .rd_addr, .rd_data, .old_addr, .old_data,
    .wr_en, .wr_addr, .wr_data,
    .free_head, .free_count, .alloc_count
  );

  rename_table u_rename_table (
    .gsi, .reset, .rd_addr, .rd_data, .old_addr, .old_data,
    .wr_en, .wr_addr, .wr_data
  );

  free_list u_free_list (
    .gsi, .reset, .alloc_count, .release_in, .free_head, .free_count
  );

endmodule

`default_nettype wire

// File: verif/rename_tb.sv
/*
 * Self-checking testbench for the rename stage. A reference model of the map
 * and the free list predicts every renamed pair, and outputs are checked each cycle.
 */
`default_nettype none

module rename_tb;

  typedef rename_pkg::instr_in_t  [1:0] in_pair_t;
  typedef rename_pkg::instr_out_t [1:0] out_pair_t;

  localparam int random_cycles = 600;
  localparam int watchdog_time = (random_cycles + 200) * 40 * 2;

  logic                        gsi;
  logic                        reset;
  logic                        in_valid;
  in_pair_t                    in_instr;
  rename_pkg::release_t  [1:0] release_in;
  logic                        resolve;
  logic                        stall;
  logic                        out_valid;
  out_pair_t                   out_instr;

  rename_pkg::phys_reg_t ref_map [32];
  rename_pkg::phys_reg_t ref_free [$];
  rename_pkg::phys_reg_t held [$];
  out_pair_t             exp_q [$];
  logic                  ref_tag;
  logic                  pend_valid;
  int                    prev_free;
  logic [31:0]           rng_state;
  string                 test_name;
  int                    tests;
  int                    checks;
  int                    errors;
  int                    test_checks;
  int                    test_errors;

  rename_stage dut (
    .gsi, .reset, .in_valid, .in_instr, .release_in, .resolve,
    .stall, .out_valid, .out_instr
  );

  always #20 gsi = ~gsi;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers and reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic rename_pkg::instr_in_t make_instr(input int rs_1, input int rs_2,
                                                       input int rd, input logic writes,
                                                       input logic jumps);
    rename_pkg::instr_in_t ins;
    ins.address   = lcg_next();
    ins.immediate = lcg_next();
    ins.rs_1      = rename_pkg::arch_reg_t'(rs_1);
    ins.rs_2      = rename_pkg::arch_reg_t'(rs_2);
    ins.rd        = rename_pkg::arch_reg_t'(rd);
    ins.writes    = writes;
    ins.jumps     = jumps;
    return ins;
  endfunction

  // Fields come from the upper bits of the generator.
  function automatic rename_pkg::instr_in_t random_instr();
    logic [31:0] r;
    r = lcg_next();
    return make_instr(int'(r[31:27]), int'(r[26:22]), int'(r[21:17]),
                      r[16] | r[15], r[14:12] == 3'd0);
  endfunction

  function automatic in_pair_t pair_of(input rename_pkg::instr_in_t older,
                                       input rename_pkg::instr_in_t younger);
    in_pair_t p;
    p[0] = older;
    p[1] = younger;
    return p;
  endfunction

  // Renames in program order, so the younger one sees the older's new mapping.
  function automatic out_pair_t expect_pair(input in_pair_t pair);
    out_pair_t res;
    logic      jumped;
    jumped = 1'b0;
    for (int k = 0; k < 2; k++) begin
      res[k].address   = pair[k].address;
      res[k].immediate = pair[k].immediate;
      res[k].prs_1     = ref_map[pair[k].rs_1];
      res[k].prs_2     = ref_map[pair[k].rs_2];
      res[k].rd        = pair[k].rd;
      res[k].jumps     = pair[k].jumps;
      if (pair[k].jumps) begin
        res[k].tag = 1'b0;
      end else begin
        res[k].tag = jumped | ref_tag;
      end
      if (pair[k].writes && pair[k].rd != '0) begin
        res[k].prd     = ref_free.pop_front();
        res[k].prd_old = ref_map[pair[k].rd];
        ref_map[pair[k].rd] = res[k].prd;
      end else begin
        res[k].prd     = '0;
        res[k].prd_old = '0;
      end
      jumped = jumped | pair[k].jumps;
    end
    if (jumped) begin
      ref_tag = 1'b1;
    end
    return res;
  endfunction

  task automatic check(input string what, input logic [31:0] want, input logic [31:0] got);
    checks++;
    if (want !== got) begin
      errors++;
      $display("error: test %s, %s: expected %0h, actual %0h", test_name, what, want, got);
    end
  endtask

  // One clock of stimulus. The pair is held back while the model says stall.
  task automatic step(input logic send, input in_pair_t pair, input int n_rel,
                      input logic clear);
    rename_pkg::release_t [1:0] rel;
    out_pair_t                  want;
    logic                       go;
    logic                       jumped;
    rel = '0;
    @(posedge gsi);
    prev_free = ref_free.size();
    go        = send && ref_free.size() >= 2;
    jumped    = go && (pair[0].jumps || pair[1].jumps);
    if (go) begin
      want = expect_pair(pair);
      exp_q.push_back(want);
    end
    if (clear && !jumped) begin
      ref_tag = 1'b0;
    end
    for (int j = 0; j < n_rel && held.size() > 0; j++) begin
      rel[j].valid = 1'b1;
      rel[j].preg  = held.pop_front();
      ref_free.push_back(rel[j].preg);
    end
    if (go) begin
      for (int k = 0; k < 2; k++) begin
        if (want[k].prd != '0) begin
          held.push_back(want[k].prd_old);
        end
      end
    end
    in_valid   <= go;
    in_instr   <= go ? pair : '0;
    release_in <= rel;
    resolve    <= clear;
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, '0, 0, 1'b0);
  endtask

  task automatic flush_releases();
    while (held.size() > 0) begin
      step(1'b0, '0, 2, 1'b0);
    end
    idle(1);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
             errors - test_errors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output comparison at the falling edge.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge gsi) begin : compare_outputs
    out_pair_t want;
    if (!reset) begin
      check("stall", 32'(prev_free < 2), 32'(stall));
      check("out_valid", 32'(pend_valid), 32'(out_valid));
      if (pend_valid) begin
        want = exp_q.pop_front();
        for (int k = 0; k < 2; k++) begin
          check($sformatf("out_instr[%0d].address", k), want[k].address, out_instr[k].address);
          check($sformatf("out_instr[%0d].immediate", k), want[k].immediate,
                out_instr[k].immediate);
          check($sformatf("out_instr[%0d].prs_1", k), 32'(want[k].prs_1),
                32'(out_instr[k].prs_1));
          check($sformatf("out_instr[%0d].prs_2", k), 32'(want[k].prs_2),
                32'(out_instr[k].prs_2));
          check($sformatf("out_instr[%0d].rd", k), 32'(want[k].rd), 32'(out_instr[k].rd));
          check($sformatf("out_instr[%0d].prd", k), 32'(want[k].prd), 32'(out_instr[k].prd));
          check($sformatf("out_instr[%0d].prd_old", k), 32'(want[k].prd_old),
                32'(out_instr[k].prd_old));
          check($sformatf("out_instr[%0d].jumps", k), 32'(want[k].jumps),
                32'(out_instr[k].jumps));
          check($sformatf("out_instr[%0d].tag", k), 32'(want[k].tag), 32'(out_instr[k].tag));
        end
      end
    end
    pend_valid = in_valid && !reset;
  end

  initial begin : watchdog
    #(watchdog_time);
    $display("timeout: the run did not finish within %0d time units", watchdog_time);
    $display("Checks failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : run_tests
    logic [31:0] r;
    int          n_rel;
    gsi        = 1'b0;
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_instr   = '0;
    release_in = '0;
    resolve    = 1'b0;
    rng_state  = 32'h39d2_6bb7;
    ref_tag    = 1'b0;
    pend_valid = 1'b0;
    prev_free  = 32;
    tests      = 0;
    checks     = 0;
    errors     = 0;
    test_name  = "reset";
    for (int i = 0; i < 32; i++) begin
      ref_map[i] = rename_pkg::phys_reg_t'(i);
    end
    for (int i = 32; i < 64; i++) begin
      ref_free.push_back(rename_pkg::phys_reg_t'(i));
    end
    repeat (5) @(posedge gsi);
    reset <= 1'b0;

    begin_test("no_writes");
    step(1'b1, pair_of(make_instr(3, 4, 5, 0, 0), make_instr(6, 7, 0, 0, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(31, 1, 2, 0, 0), make_instr(0, 9, 0, 0, 0)), 0, 1'b0);
    idle(2);
    end_test();

    begin_test("fresh_registers");
    step(1'b1, pair_of(make_instr(1, 2, 3, 1, 0), make_instr(4, 5, 6, 1, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(3, 6, 3, 1, 0), make_instr(3, 0, 7, 1, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(7, 3, 8, 1, 0), make_instr(8, 6, 9, 0, 0)), 0, 1'b0);
    idle(2);
    end_test();

    begin_test("pair_forwarding");
    step(1'b1, pair_of(make_instr(1, 2, 10, 1, 0), make_instr(10, 10, 10, 1, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(0, 1, 0, 1, 0), make_instr(0, 0, 0, 1, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(4, 5, 11, 1, 0), make_instr(11, 2, 12, 1, 0)), 0, 1'b0);
    idle(2);
    end_test();

    // Sixteen writing pairs empty a full free list.
    begin_test("drain");
    flush_releases();
    for (int i = 0; i < 16; i++) begin
      step(1'b1, pair_of(make_instr(i, 1, i + 1, 1, 0), make_instr(i + 1, 2, i + 16, 1, 0)),
           0, 1'b0);
    end
    idle(1);
    @(negedge gsi);
    check("stall after drain", 32'd1, 32'(stall));
    step(1'b0, '0, 2, 1'b0);
    idle(1);
    @(negedge gsi);
    check("stall after release", 32'd0, 32'(stall));
    step(1'b1, pair_of(make_instr(1, 2, 3, 1, 0), make_instr(3, 4, 5, 1, 0)), 0, 1'b0);
    flush_releases();
    end_test();

    begin_test("speculation_tag");
    step(1'b1, pair_of(make_instr(1, 2, 0, 0, 0), make_instr(3, 4, 0, 0, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(1, 2, 0, 0, 1), make_instr(3, 4, 5, 1, 0)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(5, 2, 6, 1, 0), make_instr(3, 4, 0, 0, 0)), 0, 1'b0);
    step(1'b0, '0, 0, 1'b1);
    step(1'b1, pair_of(make_instr(1, 2, 0, 0, 0), make_instr(3, 4, 0, 0, 1)), 0, 1'b0);
    step(1'b1, pair_of(make_instr(1, 2, 7, 1, 0), make_instr(7, 4, 0, 0, 0)), 0, 1'b1);
    step(1'b1, pair_of(make_instr(1, 2, 0, 0, 1), make_instr(3, 4, 0, 0, 0)), 0, 1'b1);
    step(1'b1, pair_of(make_instr(1, 2, 0, 0, 0), make_instr(3, 4, 0, 0, 0)), 0, 1'b1);
    step(1'b1, pair_of(make_instr(1, 2, 0, 0, 0), make_instr(3, 4, 0, 0, 0)), 0, 1'b0);
    flush_releases();
    end_test();

    // Releases lag allocation, so the list runs dry now and then.
    begin_test("random");
    for (int i = 0; i < random_cycles; i++) begin
      r     = lcg_next();
      n_rel = (r[29:28] == 2'd3) ? 2 : ((r[29:28] == 2'd2) ? 1 : 0);
      step(r[31:30] != 2'd0, pair_of(random_instr(), random_instr()), n_rel,
           r[24:22] == 3'd0);
    end
    flush_releases();
    idle(2);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/rename_pkg.sv
logic/free_list.sv
logic/rename_table.sv
logic/resolver.sv
logic/rename_stage.sv
verif/rename_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the rename stage testbench with Verilator and runs it.
# Exits nonzero unless the run reports that every check passed.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module rename_tb -f filelist.f -o rename_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/rename_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
